// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen       = 64;
  localparam int inst_width = 32;

  // ########################################
  // major opcodes
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm_32 = 7'b0011011;
  localparam logic [6:0] op        = 7'b0110011;
  localparam logic [6:0] op_32     = 7'b0111011;
  localparam logic [6:0] lui       = 7'b0110111;
  localparam logic [6:0] auipc     = 7'b0010111;
  localparam logic [6:0] jal       = 7'b1101111;
  localparam logic [6:0] jalr      = 7'b1100111;
  localparam logic [6:0] branch    = 7'b1100011;
  localparam logic [6:0] load      = 7'b0000011;
  localparam logic [6:0] store     = 7'b0100011;
  localparam logic [6:0] system    = 7'b1110011;

  // ########################################
  // alu operation, one bit per op
  localparam int alu_op_width = 19;
  localparam int alu_add      = 0;
  localparam int alu_sub      = 1;
  localparam int alu_lt       = 2;
  localparam int alu_ltu      = 3;
  localparam int alu_and      = 4;
  localparam int alu_or       = 5;
  localparam int alu_xor      = 6;
  localparam int alu_sll      = 7;
  localparam int alu_srl      = 8;
  localparam int alu_sra      = 9;
  localparam int alu_out_imm  = 10;  // passes operand b.
  localparam int alu_eq       = 11;
  localparam int alu_ne       = 12;
  localparam int alu_ge       = 13;
  localparam int alu_geu      = 14;
  localparam int alu_addw     = 15;
  localparam int alu_sllw     = 16;
  localparam int alu_srlw     = 17;
  localparam int alu_sraw     = 18;

  // load width, one-hot.
  localparam int wdt_width = 4;
  localparam int wdt8      = 0;
  localparam int wdt16     = 1;
  localparam int wdt32     = 2;
  localparam int wdt64     = 3;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;  // also funct12 and shamt.
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } inst_u;

endpackage

`default_nettype wire

// File: source/mem_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if #(
  parameter int addr_width = 16
);

  logic                    req;    // held until ready.
  logic                    we;
  logic [addr_width-1:0]   addr;   // doubleword aligned.
  logic [rv_pkg::xlen-1:0] wdata;
  logic [7:0]              wmask;
  logic [rv_pkg::xlen-1:0] rdata;  // valid with ready.
  logic                    ready;  // one-cycle pulse.

  modport requester (output req, we, addr, wdata, wmask, input rdata, ready);
  modport arbiter (input req, we, addr, wdata, wmask, output rdata, ready);

endinterface

`default_nettype wire

// File: source/decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder (
  input  wire logic                           clk,
  input  wire rv_pkg::inst_u                  inst,
  output logic [4:0]                          rd,
  output logic [4:0]                          rs1,
  output logic [4:0]                          rs2,
  output logic [rv_pkg::xlen-1:0]             imm,
  output logic                                need_imm, is_ebreak, is_auipc, is_jal, is_jalr,
  output logic                                reg_wen, mem_wen, is_load, is_branch,
  output logic                                is_unsigned, inst_not_ipl,
  output logic [rv_pkg::alu_op_width-1:0]     alu_op,
  output logic [rv_pkg::wdt_width-1:0]        wdt_op,
  output logic [7:0]                          wmask
);

  wire [rv_pkg::inst_width-1:0] raw = inst;
  wire [7:0] f3 = 8'd1 << inst.i.funct3;  // funct3 as one-hot.

  wire opc_imm    = inst.r.opcode == rv_pkg::op_imm;
  wire opc_imm_32 = inst.r.opcode == rv_pkg::op_imm_32;
  wire opc_op     = inst.r.opcode == rv_pkg::op;
  wire opc_op_32  = inst.r.opcode == rv_pkg::op_32;
  wire opc_load   = inst.r.opcode == rv_pkg::load;
  wire opc_store  = inst.r.opcode == rv_pkg::store;
  wire opc_branch = inst.r.opcode == rv_pkg::branch;
  wire opc_system = inst.r.opcode == rv_pkg::system;
  wire lui        = inst.r.opcode == rv_pkg::lui;
  wire auipc      = inst.r.opcode == rv_pkg::auipc;
  wire jal        = inst.r.opcode == rv_pkg::jal;
  wire jalr       = inst.r.opcode == rv_pkg::jalr;

  wire f7_zero = inst.r.funct7 == 7'b0000000;
  wire f7_alt  = inst.r.funct7 == 7'b0100000;
  wire sh_zero = inst.i.imm12[11:6] == 6'b000000;  // six-bit shamt on rv64.
  wire sh_alt  = inst.i.imm12[11:6] == 6'b010000;

  // ########################################
  // instruction names
  wire addi   = opc_imm & f3[0];
  wire slti   = opc_imm & f3[2];
  wire sltiu  = opc_imm & f3[3];
  wire xori   = opc_imm & f3[4];
  wire ori    = opc_imm & f3[6];
  wire andi   = opc_imm & f3[7];
  wire slli   = opc_imm & f3[1] & sh_zero;
  wire srli   = opc_imm & f3[5] & sh_zero;
  wire srai   = opc_imm & f3[5] & sh_alt;
  wire add    = opc_op & f3[0] & f7_zero;
  wire sub    = opc_op & f3[0] & f7_alt;
  wire sll    = opc_op & f3[1] & f7_zero;
  wire slt    = opc_op & f3[2] & f7_zero;
  wire sltu   = opc_op & f3[3] & f7_zero;
  wire xor_r  = opc_op & f3[4] & f7_zero;
  wire srl    = opc_op & f3[5] & f7_zero;
  wire sra    = opc_op & f3[5] & f7_alt;
  wire or_r   = opc_op & f3[6] & f7_zero;
  wire and_r  = opc_op & f3[7] & f7_zero;
  wire addiw  = opc_imm_32 & f3[0];
  wire slliw  = opc_imm_32 & f3[1] & f7_zero;
  wire srliw  = opc_imm_32 & f3[5] & f7_zero;
  wire sraiw  = opc_imm_32 & f3[5] & f7_alt;
  wire sllw   = opc_op_32 & f3[1] & f7_zero;
  wire srlw   = opc_op_32 & f3[5] & f7_zero;
  wire sraw   = opc_op_32 & f3[5] & f7_alt;
  wire beq    = opc_branch & f3[0];
  wire bne    = opc_branch & f3[1];
  wire blt    = opc_branch & f3[4];
  wire bge    = opc_branch & f3[5];
  wire bltu   = opc_branch & f3[6];
  wire bgeu   = opc_branch & f3[7];
  wire lb     = opc_load & f3[0];
  wire lh     = opc_load & f3[1];
  wire lw     = opc_load & f3[2];
  wire ld     = opc_load & f3[3];
  wire lbu    = opc_load & f3[4];
  wire lhu    = opc_load & f3[5];
  wire lwu    = opc_load & f3[6];
  wire sd     = opc_store & f3[3];
  wire ebreak = opc_system & f3[0] & (inst.i.imm12 == 12'h001);

  wire any_load = lb | lh | lw | ld | lbu | lhu | lwu;
  wire branch   = beq | bne | blt | bge | bltu | bgeu;

  // ########################################
  // immediate by format
  wire i_type = opc_imm | opc_imm_32 | opc_load | jalr;
  wire u_type = lui | auipc;

  wire [63:0] imm_i = {{52{raw[31]}}, inst.i.imm12};
  wire [63:0] imm_u = {{32{raw[31]}}, raw[31:12], 12'd0};
  wire [63:0] imm_j = {{44{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
  wire [63:0] imm_s = {{52{raw[31]}}, raw[31:25], raw[11:7]};
  wire [63:0] imm_b = {{52{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};

  assign imm = ({64{i_type}} & imm_i) | ({64{u_type}} & imm_u) | ({64{jal}} & imm_j) |
               ({64{opc_store}} & imm_s) | ({64{opc_branch}} & imm_b);

  assign rd  = inst.r.rd;
  assign rs1 = inst.r.rs1;
  assign rs2 = inst.r.rs2;

  // ########################################
  // control strobes
  assign alu_op[rv_pkg::alu_add]     = addi | add | auipc | jal | jalr | any_load | sd;
  assign alu_op[rv_pkg::alu_sub]     = sub;
  assign alu_op[rv_pkg::alu_lt]      = slti | slt | blt;
  assign alu_op[rv_pkg::alu_ltu]     = sltiu | sltu | bltu;
  assign alu_op[rv_pkg::alu_and]     = andi | and_r;
  assign alu_op[rv_pkg::alu_or]      = ori | or_r;
  assign alu_op[rv_pkg::alu_xor]     = xori | xor_r;
  assign alu_op[rv_pkg::alu_sll]     = slli | sll;
  assign alu_op[rv_pkg::alu_srl]     = srli | srl;
  assign alu_op[rv_pkg::alu_sra]     = srai | sra;
  assign alu_op[rv_pkg::alu_out_imm] = lui;
  assign alu_op[rv_pkg::alu_eq]      = beq;
  assign alu_op[rv_pkg::alu_ne]      = bne;
  assign alu_op[rv_pkg::alu_ge]      = bge;
  assign alu_op[rv_pkg::alu_geu]     = bgeu;
  assign alu_op[rv_pkg::alu_addw]    = addiw;
  assign alu_op[rv_pkg::alu_sllw]    = slliw | sllw;
  assign alu_op[rv_pkg::alu_srlw]    = srliw | srlw;
  assign alu_op[rv_pkg::alu_sraw]    = sraiw | sraw;

  assign need_imm  = opc_imm | opc_imm_32 | u_type | jal | jalr | any_load | sd;
  assign reg_wen   = opc_imm | opc_imm_32 | opc_op | opc_op_32 | u_type | jal | jalr |
                     any_load;
  assign mem_wen   = sd;
  assign wmask     = sd ? 8'hff : 8'h00;  // doubleword stores only.
  assign is_ebreak = ebreak;
  assign is_auipc  = auipc;
  assign is_jal    = jal;
  assign is_jalr   = jalr;
  assign is_load   = any_load;
  assign is_branch = branch;

  assign wdt_op[rv_pkg::wdt8]  = lb | lbu;
  assign wdt_op[rv_pkg::wdt16] = lh | lhu;
  assign wdt_op[rv_pkg::wdt32] = lw | lwu;
  assign wdt_op[rv_pkg::wdt64] = ld;
  assign is_unsigned           = lbu | lhu | lwu;

  assign inst_not_ipl = ~(addi | slti | sltiu | xori | ori | andi | slli | srli | srai |
                          add | sub | sll | slt | sltu | xor_r | srl | sra | or_r | and_r |
                          addiw | slliw | srliw | sraiw | sllw | srlw | sraw |
                          u_type | jal | jalr | branch | any_load | sd | ebreak);

  a_alu_onehot: assert property (@(posedge clk) !inst_not_ipl |-> $onehot0(alu_op));

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  wire logic [rv_pkg::xlen-1:0]         a,
  input  wire logic [rv_pkg::xlen-1:0]         b,
  input  wire logic [rv_pkg::alu_op_width-1:0] alu_op,
  output logic      [rv_pkg::xlen-1:0]         result
);

  logic [31:0] add_w;  // word results before sign extension.
  logic [31:0] sll_w;
  logic [31:0] srl_w;
  logic [31:0] sra_w;

  assign add_w = a[31:0] + b[31:0];
  assign sll_w = a[31:0] << b[4:0];
  assign srl_w = a[31:0] >> b[4:0];
  assign sra_w = $signed(a[31:0]) >>> b[4:0];

  always_comb begin
    case (1'b1)
      alu_op[rv_pkg::alu_add]:     result = a + b;
      alu_op[rv_pkg::alu_sub]:     result = a - b;
      alu_op[rv_pkg::alu_lt]:      result = {63'd0, $signed(a) < $signed(b)};
      alu_op[rv_pkg::alu_ltu]:     result = {63'd0, a < b};
      alu_op[rv_pkg::alu_and]:     result = a & b;
      alu_op[rv_pkg::alu_or]:      result = a | b;
      alu_op[rv_pkg::alu_xor]:     result = a ^ b;
      alu_op[rv_pkg::alu_sll]:     result = a << b[5:0];
      alu_op[rv_pkg::alu_srl]:     result = a >> b[5:0];
      alu_op[rv_pkg::alu_sra]:     result = $signed(a) >>> b[5:0];
      alu_op[rv_pkg::alu_out_imm]: result = b;  // lui.
      alu_op[rv_pkg::alu_eq]:      result = {63'd0, a == b};
      alu_op[rv_pkg::alu_ne]:      result = {63'd0, a != b};
      alu_op[rv_pkg::alu_ge]:      result = {63'd0, $signed(a) >= $signed(b)};
      alu_op[rv_pkg::alu_geu]:     result = {63'd0, a >= b};
      alu_op[rv_pkg::alu_addw]:    result = {{32{add_w[31]}}, add_w};
      alu_op[rv_pkg::alu_sllw]:    result = {{32{sll_w[31]}}, sll_w};
      alu_op[rv_pkg::alu_srlw]:    result = {{32{srl_w[31]}}, srl_w};
      alu_op[rv_pkg::alu_sraw]:    result = {{32{sra_w[31]}}, sra_w};
      default:                     result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic [4:0]              rs1,
  input  wire logic [4:0]              rs2,
  output logic      [rv_pkg::xlen-1:0] rd1,
  output logic      [rv_pkg::xlen-1:0] rd2,
  input  wire logic                    wen,
  input  wire logic [4:0]              wa,
  input  wire logic [rv_pkg::xlen-1:0] wd
);

  logic [rv_pkg::xlen-1:0] regs [32];

  assign rd1 = regs[rs1];
  assign rd2 = regs[rs2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wa != 5'd0) begin  // x0 stays zero.
      regs[wa] <= wd;
    end
  end

endmodule

`default_nettype wire

// File: source/sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module sequencer #(
  parameter int                      addr_width = 16,
  parameter logic [rv_pkg::xlen-1:0] reset_pc   = '0
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  mem_bus_if.requester                 fetch,
  input  wire logic                    is_ebreak, is_jal, is_jalr, is_branch, is_load,
  input  wire logic                    mem_wen, reg_wen, need_imm, is_auipc, inst_not_ipl,
  input  wire logic [rv_pkg::xlen-1:0] imm,
  input  wire logic [4:0]              rd,
  output rv_pkg::inst_u                ir,
  output logic      [rv_pkg::xlen-1:0] alu_a,
  output logic      [rv_pkg::xlen-1:0] alu_b,
  input  wire logic [rv_pkg::xlen-1:0] alu_result,
  input  wire logic [rv_pkg::xlen-1:0] rd1,
  input  wire logic [rv_pkg::xlen-1:0] rd2,
  output logic                         wen,
  output logic      [4:0]              wa,
  output logic      [rv_pkg::xlen-1:0] wd,
  output logic                         ls_start,
  output logic                         ls_we,
  output logic      [rv_pkg::xlen-1:0] ls_addr,
  output logic      [rv_pkg::xlen-1:0] ls_wdata,
  input  wire logic                    ls_done,
  input  wire logic [rv_pkg::xlen-1:0] ls_data,
  output logic                         halted,
  output logic                         illegal
);

  localparam logic [2:0] s_fetch = 3'd0;
  localparam logic [2:0] s_exec  = 3'd1;
  localparam logic [2:0] s_mem   = 3'd2;
  localparam logic [2:0] s_wb    = 3'd3;
  localparam logic [2:0] s_halt  = 3'd4;

  logic [2:0]              state;
  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] next_pc;
  logic [rv_pkg::xlen-1:0] load_q;     // load result held for wb.
  logic                    fetch_req;

  assign fetch.req   = fetch_req;
  assign fetch.we    = 1'b0;
  assign fetch.addr  = {pc[addr_width-1:3], 3'b000};
  assign fetch.wdata = '0;
  assign fetch.wmask = 8'h00;

  assign alu_a = (is_auipc || is_jal) ? pc : rd1;
  assign alu_b = need_imm ? imm : rd2;

  assign ls_start = (state == s_exec) && (is_load || mem_wen);
  assign ls_we    = mem_wen;
  assign ls_addr  = alu_result;
  assign ls_wdata = rd2;

  // ########################################
  // writeback and next pc
  assign pc_plus4 = pc + 64'd4;
  assign wen      = (state == s_wb) && reg_wen;
  assign wa       = rd;
  assign wd       = (is_jal || is_jalr) ? pc_plus4 : (is_load ? load_q : alu_result);

  always_comb begin
    if (is_jal) begin
      next_pc = alu_result;
    end else if (is_jalr) begin
      next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
    end else if (is_branch && alu_result[0]) begin  // compare result is the taken flag.
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= s_fetch;
      pc        <= reset_pc;
      fetch_req <= 1'b0;
      halted    <= 1'b0;
      illegal   <= 1'b0;
    end else begin
      case (state)
        s_fetch: begin
          fetch_req <= !fetch.ready;
          if (fetch.ready) begin
            state <= s_exec;
          end
        end
        s_exec: begin
          if (is_ebreak || inst_not_ipl) begin
            state   <= s_halt;
            halted  <= 1'b1;
            illegal <= inst_not_ipl;
          end else if (is_load || mem_wen) begin
            state <= s_mem;
          end else begin
            state <= s_wb;
          end
        end
        s_mem: begin
          if (ls_done) begin
            state <= s_wb;
          end
        end
        s_wb: begin
          pc        <= next_pc;
          fetch_req <= 1'b1;  // next fetch starts with no idle cycle.
          state     <= s_fetch;
        end
        s_halt:  state <= s_halt;
        default: state <= s_fetch;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_fetch && fetch.ready) begin
      ir <= pc[2] ? fetch.rdata[63:32] : fetch.rdata[31:0];  // pick the word half.
    end
    if (state == s_mem && ls_done) begin
      load_q <= ls_data;
    end
  end

endmodule

`default_nettype wire

// File: source/load_store_unit.sv
`timescale 1ns/100ps
`default_nettype none

module load_store_unit #(
  parameter int addr_width = 16
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         start,
  input  wire logic                         we,
  input  wire logic [rv_pkg::xlen-1:0]      addr,
  input  wire logic [rv_pkg::xlen-1:0]      wdata,
  input  wire logic [7:0]                   wmask,
  input  wire logic [rv_pkg::wdt_width-1:0] wdt_op,
  input  wire logic                         is_unsigned,
  output logic                              done,
  output logic      [rv_pkg::xlen-1:0]      load_data,
  mem_bus_if.requester                      bus
);

  logic                    busy;  // request outstanding.
  logic                    we_q;
  logic [addr_width-1:0]   addr_q;
  logic [rv_pkg::xlen-1:0] wdata_q;
  logic [7:0]              wmask_q;
  logic [rv_pkg::xlen-1:0] shifted;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (bus.ready) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      we_q    <= we;
      addr_q  <= addr[addr_width-1:0];
      wdata_q <= wdata;
      wmask_q <= wmask;
    end
  end

  assign bus.req   = busy;
  assign bus.we    = we_q;
  assign bus.addr  = {addr_q[addr_width-1:3], 3'b000};
  assign bus.wdata = wdata_q;
  assign bus.wmask = wmask_q;
  assign done      = bus.ready;

  // ########################################
  // load extraction
  assign shifted = bus.rdata >> {addr_q[2:0], 3'b000};  // byte lane to bit 0.

  always_comb begin
    case (1'b1)
      wdt_op[rv_pkg::wdt8]:  load_data = {{56{shifted[7] & ~is_unsigned}}, shifted[7:0]};
      wdt_op[rv_pkg::wdt16]: load_data = {{48{shifted[15] & ~is_unsigned}}, shifted[15:0]};
      wdt_op[rv_pkg::wdt32]: load_data = {{32{shifted[31] & ~is_unsigned}}, shifted[31:0]};
      wdt_op[rv_pkg::wdt64]: load_data = shifted;
      default:               load_data = '0;
    endcase
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter #(
  parameter int addr_width = 16
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  mem_bus_if.arbiter                   fetch,
  mem_bus_if.arbiter                   data,
  output logic                         mem_req,
  output logic                         mem_we,
  output logic      [addr_width-1:0]   mem_addr,
  output logic      [rv_pkg::xlen-1:0] mem_wdata,
  output logic      [7:0]              mem_wmask,
  input  wire logic [rv_pkg::xlen-1:0] mem_rdata,
  input  wire logic                    mem_ready
);

  logic locked;  // grant held until mem_ready.
  logic owner;   // 1 for the data side.
  logic sel;

  assign sel = locked ? owner : data.req;  // data wins a tie.

  assign mem_req   = sel ? data.req   : fetch.req;
  assign mem_we    = sel ? data.we    : fetch.we;
  assign mem_addr  = sel ? data.addr  : fetch.addr;
  assign mem_wdata = sel ? data.wdata : fetch.wdata;
  assign mem_wmask = sel ? data.wmask : fetch.wmask;

  assign data.ready  = mem_ready & sel;
  assign fetch.ready = mem_ready & ~sel;
  assign data.rdata  = sel ? mem_rdata : '0;
  assign fetch.rdata = sel ? '0 : mem_rdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      locked <= 1'b0;
      owner  <= 1'b0;
    end else if (mem_ready) begin
      locked <= 1'b0;
    end else if (mem_req && !locked) begin
      locked <= 1'b1;
      owner  <= sel;
    end
  end

  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && !mem_ready |=> mem_req && $stable(mem_addr));

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
  parameter int                      addr_width = 16,
  parameter logic [rv_pkg::xlen-1:0] reset_pc   = '0
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  output logic                         mem_req,
  output logic                         mem_we,
  output logic      [addr_width-1:0]   mem_addr,
  output logic      [rv_pkg::xlen-1:0] mem_wdata,
  output logic      [7:0]              mem_wmask,
  input  wire logic [rv_pkg::xlen-1:0] mem_rdata,
  input  wire logic                    mem_ready,
  output logic                         halted,
  output logic                         illegal
);

  rv_pkg::inst_u                    ir;
  logic [4:0]                       rd, rs1, rs2, wa;
  logic [rv_pkg::xlen-1:0]          imm, alu_a, alu_b, alu_result, rd1, rd2, wd;
  logic [rv_pkg::xlen-1:0]          ls_addr, ls_wdata, ls_data;
  logic [rv_pkg::alu_op_width-1:0]  alu_op;
  logic [rv_pkg::wdt_width-1:0]     wdt_op;
  logic [7:0]                       wmask;
  logic need_imm, is_ebreak, is_auipc, is_jal, is_jalr, reg_wen, mem_wen;
  logic is_load, is_branch, is_unsigned, inst_not_ipl;
  logic wen, ls_start, ls_we, ls_done;

  mem_bus_if #(.addr_width(addr_width)) fetch_bus ();
  mem_bus_if #(.addr_width(addr_width)) data_bus ();

  decoder u_decoder (
    .clk(clk), .inst(ir), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .need_imm(need_imm),
    .is_ebreak(is_ebreak), .is_auipc(is_auipc), .is_jal(is_jal), .is_jalr(is_jalr),
    .reg_wen(reg_wen), .mem_wen(mem_wen), .is_load(is_load), .is_branch(is_branch),
    .is_unsigned(is_unsigned), .inst_not_ipl(inst_not_ipl), .alu_op(alu_op),
    .wdt_op(wdt_op), .wmask(wmask)
  );

  alu u_alu (.a(alu_a), .b(alu_b), .alu_op(alu_op), .result(alu_result));

  regfile u_regfile (
    .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
    .wen(wen), .wa(wa), .wd(wd)
  );

  sequencer #(.addr_width(addr_width), .reset_pc(reset_pc)) u_sequencer (
    .clk(clk), .rst_n(rst_n), .fetch(fetch_bus.requester),
    .is_ebreak(is_ebreak), .is_jal(is_jal), .is_jalr(is_jalr), .is_branch(is_branch),
    .is_load(is_load), .mem_wen(mem_wen), .reg_wen(reg_wen), .need_imm(need_imm),
    .is_auipc(is_auipc), .inst_not_ipl(inst_not_ipl), .imm(imm), .rd(rd), .ir(ir),
    .alu_a(alu_a), .alu_b(alu_b), .alu_result(alu_result), .rd1(rd1), .rd2(rd2),
    .wen(wen), .wa(wa), .wd(wd), .ls_start(ls_start), .ls_we(ls_we), .ls_addr(ls_addr),
    .ls_wdata(ls_wdata), .ls_done(ls_done), .ls_data(ls_data),
    .halted(halted), .illegal(illegal)
  );

  load_store_unit #(.addr_width(addr_width)) u_lsu (
    .clk(clk), .rst_n(rst_n), .start(ls_start), .we(ls_we), .addr(ls_addr),
    .wdata(ls_wdata), .wmask(wmask), .wdt_op(wdt_op), .is_unsigned(is_unsigned),
    .done(ls_done), .load_data(ls_data), .bus(data_bus.requester)
  );

  mem_arbiter #(.addr_width(addr_width)) u_arbiter (
    .clk(clk), .rst_n(rst_n), .fetch(fetch_bus.arbiter), .data(data_bus.arbiter),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wmask(mem_wmask), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
  );

endmodule

`default_nettype wire

// File: test/rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

  localparam int rows       = 14;
  localparam int timeout    = 2000;
  localparam int opc_opi    = 'h13;
  localparam int opc_opi32  = 'h1b;
  localparam int opc_op     = 'h33;
  localparam int opc_op32   = 'h3b;
  localparam int opc_lui    = 'h37;
  localparam int opc_auipc  = 'h17;
  localparam int opc_jalr   = 'h67;
  localparam int opc_load   = 'h03;
  localparam logic [63:0] marker = 64'h5a5a_0100_a5a5_0100;  // initial word at 0x100.
  localparam logic [63:0] ld_src = 64'h8123_4567_89ab_cdef;

  logic        clk;
  logic        rst_n;
  logic        mem_req;
  logic        mem_we;
  logic [15:0] mem_addr;
  logic [63:0] mem_wdata;
  logic [7:0]  mem_wmask;
  logic [63:0] mem_rdata;
  logic        mem_ready;
  logic        halted;
  logic        illegal;

  logic [63:0] mem [8192];
  integer      seed;
  int          wait_left;
  logic        pending;

  logic [31:0] prog [rows][6];
  logic [63:0] init_data [rows];
  logic [63:0] expect_val [rows];
  logic        exp_halt [rows];
  logic        exp_ill [rows];
  string       names [rows];
  int          n_rows;

  rv_core #(.addr_width(16), .reset_pc(64'd0)) dut_i (
    .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_wmask(mem_wmask), .mem_rdata(mem_rdata),
    .mem_ready(mem_ready), .halted(halted), .illegal(illegal)
  );

  always #20 clk = ~clk;

  // ########################################
  // memory model, 0 to 3 wait cycles
  always @(posedge clk) begin
    mem_ready <= 1'b0;
    if (!rst_n) begin
      pending = 1'b0;
    end else if (mem_req && !mem_ready) begin
      if (!pending) begin
        pending   = 1'b1;
        wait_left = $random(seed) & 3;
      end
      if (wait_left == 0) begin
        pending   = 1'b0;
        mem_ready <= 1'b1;
        mem_rdata <= mem[mem_addr[15:3]];
        if (mem_we) begin
          for (int b = 0; b < 8; b++) begin
            if (mem_wmask[b]) mem[mem_addr[15:3]][b*8 +: 8] = mem_wdata[b*8 +: 8];
          end
        end
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // ########################################
  // instruction formats
  function automatic logic [31:0] i_fmt(input int imm, rs1, f3, rd, opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] r_fmt(input int f7, rs2, rs1, f3, rd, opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] s_fmt(input int imm, rs2, rs1, f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_fmt(input int imm, rs2, rs1, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_fmt(input int imm, rd, opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] j_fmt(input int imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  // four body words, then sd x3 to 0x100 and ebreak.
  task automatic add_row(input string nm, input logic [31:0] w0, w1, w2, w3,
                         input logic [63:0] data, expv, input logic ill);
    prog[n_rows][0]    = w0;
    prog[n_rows][1]    = w1;
    prog[n_rows][2]    = w2;
    prog[n_rows][3]    = w3;
    prog[n_rows][4]    = s_fmt(256, 3, 0, 3);
    prog[n_rows][5]    = 32'h0010_0073;
    init_data[n_rows]  = data;
    expect_val[n_rows] = expv;
    exp_halt[n_rows]   = 1'b1;
    exp_ill[n_rows]    = ill;
    names[n_rows]      = nm;
    n_rows++;
  endtask

  task automatic build_table;
    logic [31:0] nop;
    nop    = i_fmt(0, 0, 0, 0, opc_opi);
    n_rows = 0;
    add_row("slti_xori", i_fmt(-5, 0, 0, 3, opc_opi), i_fmt(-4, 3, 2, 3, opc_opi),
            i_fmt(2, 3, 3, 3, opc_opi), i_fmt(-1, 3, 4, 3, opc_opi),
            64'd0, 64'hffff_ffff_ffff_fffe, 1'b0);
    add_row("andi_slli", i_fmt('h5a5, 0, 0, 3, opc_opi), i_fmt('hf0, 3, 7, 3, opc_opi),
            i_fmt(-2048, 3, 6, 3, opc_opi), i_fmt(4, 3, 1, 3, opc_opi),
            64'd0, 64'hffff_ffff_ffff_8a00, 1'b0);
    add_row("srai_srli", i_fmt(-256, 0, 0, 3, opc_opi), i_fmt('h404, 3, 5, 3, opc_opi),
            i_fmt(52, 3, 5, 3, opc_opi), i_fmt(1, 3, 0, 3, opc_opi),
            64'd0, 64'h0000_0000_0000_1000, 1'b0);
    add_row("add_sub_sll", i_fmt(7, 0, 0, 1, opc_opi), r_fmt(0, 1, 1, 0, 2, opc_op),
            r_fmt('h20, 2, 1, 0, 3, opc_op), r_fmt(0, 1, 3, 1, 3, opc_op),
            64'd0, 64'hffff_ffff_ffff_fc80, 1'b0);
    add_row("sra_sltu", i_fmt(-64, 0, 0, 1, opc_opi), i_fmt(3, 0, 0, 2, opc_opi),
            r_fmt('h20, 2, 1, 5, 2, opc_op), r_fmt(0, 2, 1, 3, 3, opc_op),
            64'd0, 64'h0000_0000_0000_0001, 1'b0);
    add_row("addiw_sraw", i_fmt(-1, 0, 0, 1, opc_opi), i_fmt(33, 1, 5, 1, opc_opi),
            i_fmt(5, 1, 0, 2, opc_opi32), r_fmt('h20, 2, 2, 5, 3, opc_op32),
            64'd0, 64'hffff_ffff_f800_0000, 1'b0);
    add_row("lui_auipc", u_fmt('h12345, 1, opc_lui), u_fmt(1, 2, opc_auipc),
            r_fmt(0, 2, 1, 0, 3, opc_op), nop, 64'd0, 64'h0000_0000_1234_6004, 1'b0);
    add_row("lb_lbu", i_fmt('h201, 0, 0, 1, opc_load), i_fmt('h203, 0, 4, 2, opc_load),
            r_fmt(0, 2, 1, 0, 3, opc_op), nop, ld_src, 64'h0000_0000_0000_0056, 1'b0);
    add_row("lh_lhu", i_fmt('h202, 0, 1, 1, opc_load), i_fmt('h206, 0, 5, 2, opc_load),
            r_fmt(0, 2, 1, 4, 3, opc_op), nop, ld_src, 64'hffff_ffff_ffff_0888, 1'b0);
    add_row("lw_lwu", i_fmt('h204, 0, 2, 1, opc_load), i_fmt('h200, 0, 6, 2, opc_load),
            r_fmt(0, 2, 1, 4, 3, opc_op), nop, ld_src, 64'hffff_ffff_0888_8888, 1'b0);
    add_row("ld", i_fmt('h200, 0, 3, 3, opc_load), nop, nop, nop, ld_src, ld_src, 1'b0);
    // bne taken over the addi, beq falls through.
    add_row("branches", i_fmt(5, 0, 0, 3, opc_opi), b_fmt(8, 0, 3, 1),
            i_fmt(99, 0, 0, 3, opc_opi), b_fmt(8, 0, 3, 0),
            64'd0, 64'h0000_0000_0000_0005, 1'b0);
    add_row("jal_jalr", j_fmt(8, 1), j_fmt(12, 0), i_fmt('h30, 1, 0, 3, opc_opi),
            i_fmt(1, 1, 0, 0, opc_jalr), 64'd0, 64'h0000_0000_0000_0034, 1'b0);
    add_row("illegal", 32'hffff_ffff, nop, nop, nop, 64'd0, marker, 1'b1);
  endtask

  task automatic load_program(input int r);
    for (int a = 0; a < 8192; a++) begin
      mem[a] = 64'd0;
    end
    for (int k = 0; k < 3; k++) begin
      mem[k] = {prog[r][2*k+1], prog[r][2*k]};
    end
    mem['h20] = marker;
    mem['h40] = init_data[r];
  endtask

  task automatic wait_for_halt(output logic ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < timeout) begin
      @(negedge clk);
      ok = halted;
      cycles++;
    end
  endtask

  initial begin
    logic ok;
    logic row_ok;
    logic timed_out;
    int   pass_cnt;
    int   fail_cnt;
    clk       = 1'b0;
    rst_n     <= 1'b0;
    mem_rdata <= 64'd0;
    mem_ready <= 1'b0;
    pending   = 1'b0;
    wait_left = 0;
    seed      = 5;
    pass_cnt  = 0;
    fail_cnt  = 0;
    timed_out = 1'b0;
    build_table();

    for (int r = 0; r < n_rows && !timed_out; r++) begin
      @(posedge clk);
      rst_n <= 1'b0;
      load_program(r);
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      wait_for_halt(ok);
      row_ok = 1'b1;
      if (!ok) begin
        $display("test %0d %s: halted did not rise within %0d cycles", r, names[r], timeout);
        timed_out = 1'b1;
        row_ok    = 1'b0;
      end else begin
        repeat (4) @(negedge clk);  // halt is permanent until reset.
        if (mem['h20] !== expect_val[r]) begin
          $display("error: test %0d mem[0x100] got %h expected %h", r, mem['h20],
                   expect_val[r]);
          row_ok = 1'b0;
        end
        if (halted !== exp_halt[r]) begin
          $display("error: test %0d halted got %h expected %h", r, halted, exp_halt[r]);
          row_ok = 1'b0;
        end
        if (illegal !== exp_ill[r]) begin
          $display("error: test %0d illegal got %h expected %h", r, illegal, exp_ill[r]);
          row_ok = 1'b0;
        end
      end
      if (row_ok) begin
        pass_cnt++;
        $display("test %0d %s: ok", r, names[r]);
      end else begin
        fail_cnt++;
        $display("test %0d %s: FAILED", r, names[r]);
      end
    end

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_core.f
source/rv_pkg.sv
source/mem_bus_if.sv
source/decoder.sv
source/alu.sv
source/regfile.sv
source/sequencer.sv
source/load_store_unit.sv
source/mem_arbiter.sv
source/rv_core.sv
test/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
RTL_TOP   ?= rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
